// File: verilog/trap_mon_macros.svh
// Trap monitor widths and counts

`ifndef TRAP_MON_MACROS_SVH
`define TRAP_MON_MACROS_SVH

// Width of the program counter and of the mepc CSR
`define TM_XLEN 32

// Number of synchronous causes that get their own mepc entry
// This also sets the width of every cause vector
`define TM_NUM_CAUSES 5

// Number of privilege rules, one error bit each
`define TM_NUM_PRIV_RULES 4

`endif

// File: verilog/trap_mon_pkg.sv
// Trap monitor types
`default_nettype none

package trap_mon_pkg;

  // Privilege levels as the core encodes them
  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // Tracked exception causes
  // The value is the index into the cause vectors of the monitor
  typedef enum logic [2:0] {
    CAUSE_BUS_FAULT = 3'd0,
    CAUSE_ILLEGAL   = 3'd1,
    CAUSE_EBREAK    = 3'd2,
    CAUSE_ECALL_U   = 3'd3,
    CAUSE_ECALL_M   = 3'd4
  } trap_cause_e;

  // mcause exception codes for the synchronous causes above
  typedef enum logic [4:0] {
    EXC_INSTR_BUS_FAULT = 5'd1,
    EXC_ILLEGAL         = 5'd2,
    EXC_BREAKPOINT      = 5'd3,
    EXC_ECALL_U         = 5'd8,
    EXC_ECALL_M         = 5'd11
  } exc_code_e;

  // Bit positions in the privilege error vector
  typedef enum logic [1:0] {
    RULE_CONSISTENT = 2'd0,
    RULE_TO_U       = 2'd1,
    RULE_TO_M       = 2'd2,
    RULE_TRAP_M     = 2'd3
  } priv_rule_e;

endpackage

`default_nettype wire

// File: verilog/exc_classifier.sv
// Writeback exception classifier
`timescale 1ns/10ps
`default_nettype none

module exc_classifier import trap_mon_pkg::*; (
  input  logic        wb_valid_i,
  input  logic        wb_bus_err_i,
  input  logic        wb_illegal_i,
  input  logic        wb_ecall_i,
  input  logic        wb_ebreak_i,
  input  logic        irq_ack_i,
  input  logic        debug_mode_i,
  input  priv_lvl_e   priv_lvl_i,
  output logic        expect_vld_o,
  output trap_cause_e expect_cause_o
);

  // High when the instruction carries any synchronous exception at all
  logic any_exc;

  ////////////////////
  // Cause priority
  ////////////////////

  // A fetch bus error wins over everything the decoder reports
  // Illegal comes next, then ecall, and ebreak has the lowest priority
  always_comb begin
    any_exc        = 1'b1;
    expect_cause_o = CAUSE_BUS_FAULT;
    if (wb_bus_err_i) begin
      expect_cause_o = CAUSE_BUS_FAULT;
    end else if (wb_illegal_i) begin
      expect_cause_o = CAUSE_ILLEGAL;
    end else if (wb_ecall_i) begin
      // The ecall cause depends on the mode the ecall executed in
      expect_cause_o = (priv_lvl_i == PRIV_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
    end else if (wb_ebreak_i) begin
      expect_cause_o = CAUSE_EBREAK;
    end else begin
      any_exc = 1'b0;
    end
  end

  // A taken interrupt replaces the instruction in writeback, so it never traps
  // In debug mode exceptions do not update mepc and nothing is expected
  assign expect_vld_o = wb_valid_i && any_exc && !irq_ack_i && !debug_mode_i;

endmodule

`default_nettype wire

// File: verilog/first_pc_bank.sv
// First PC per cause
`timescale 1ns/10ps
`default_nettype none
`include "trap_mon_macros.svh"

module first_pc_bank import trap_mon_pkg::*; (
  input  logic                                     clk,
  input  logic                                     rst_ni,
  input  logic                                     cap_i,
  input  trap_cause_e                              cap_cause_i,
  input  logic [`TM_XLEN-1:0]                      cap_pc_i,
  output logic [`TM_NUM_CAUSES-1:0]                vld_o,
  output logic [`TM_NUM_CAUSES-1:0][`TM_XLEN-1:0]  pc_o
);

  logic [`TM_NUM_CAUSES-1:0]               vld_q;
  logic [`TM_NUM_CAUSES-1:0][`TM_XLEN-1:0] pc_q;
  // One-hot write enable for entries that are still empty
  logic [`TM_NUM_CAUSES-1:0]               cap_sel;

  always_comb begin
    for (int i = 0; i < `TM_NUM_CAUSES; i++) begin
      cap_sel[i] = cap_i && (int'(cap_cause_i) == i) && !vld_q[i];
    end
  end

  // Valid bits are sticky until reset
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_q | cap_sel;
    end
  end

  // The PC is written once, together with the valid bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < `TM_NUM_CAUSES; i++) begin
      if (cap_sel[i]) begin
        pc_q[i] <= cap_pc_i;
      end
    end
  end

  assign vld_o = vld_q;
  assign pc_o  = pc_q;

endmodule

`default_nettype wire

// File: verilog/mepc_monitor.sv
// mepc against trapping PC
`timescale 1ns/10ps
`default_nettype none
`include "trap_mon_macros.svh"

module mepc_monitor import trap_mon_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      wb_valid_i,
  input  logic [`TM_XLEN-1:0]       wb_pc_i,
  input  logic                      wb_bus_err_i,
  input  logic                      wb_illegal_i,
  input  logic                      wb_ebreak_i,
  input  logic                      wb_ecall_i,
  input  logic                      irq_ack_i,
  input  logic                      debug_mode_i,
  input  priv_lvl_e                 priv_lvl_i,
  input  logic                      save_cause_i,
  input  logic                      save_irq_i,
  input  exc_code_e                 save_code_i,
  input  logic [`TM_XLEN-1:0]       mepc_n_i,
  output logic [`TM_NUM_CAUSES-1:0] mepc_err_o
);

  logic                                    expect_vld;
  trap_cause_e                             expect_cause;
  logic                                    save_known;
  logic                                    save_vld;
  trap_cause_e                             save_cause;
  logic [`TM_NUM_CAUSES-1:0]               exp_vld;
  logic [`TM_NUM_CAUSES-1:0]               act_vld;
  logic [`TM_NUM_CAUSES-1:0][`TM_XLEN-1:0] exp_pc;
  logic [`TM_NUM_CAUSES-1:0][`TM_XLEN-1:0] act_pc;
  logic [`TM_NUM_CAUSES-1:0]               mismatch;
  logic [`TM_NUM_CAUSES-1:0]               err_q;

  exc_classifier u_classifier (
    .wb_valid_i     (wb_valid_i),
    .wb_bus_err_i   (wb_bus_err_i),
    .wb_illegal_i   (wb_illegal_i),
    .wb_ecall_i     (wb_ecall_i),
    .wb_ebreak_i    (wb_ebreak_i),
    .irq_ack_i      (irq_ack_i),
    .debug_mode_i   (debug_mode_i),
    .priv_lvl_i     (priv_lvl_i),
    .expect_vld_o   (expect_vld),
    .expect_cause_o (expect_cause)
  );

  // Expected side records the PC of the first instruction that should trap
  first_pc_bank u_expected (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .cap_i       (expect_vld),
    .cap_cause_i (expect_cause),
    .cap_pc_i    (wb_pc_i),
    .vld_o       (exp_vld),
    .pc_o        (exp_pc)
  );

  ////////////////////
  // Saved cause decode
  ////////////////////

  always_comb begin
    save_known = 1'b1;
    save_cause = CAUSE_BUS_FAULT;
    case (save_code_i)
      EXC_INSTR_BUS_FAULT: save_cause = CAUSE_BUS_FAULT;
      EXC_ILLEGAL:         save_cause = CAUSE_ILLEGAL;
      EXC_BREAKPOINT:      save_cause = CAUSE_EBREAK;
      EXC_ECALL_U:         save_cause = CAUSE_ECALL_U;
      EXC_ECALL_M:         save_cause = CAUSE_ECALL_M;
      default:             save_known = 1'b0;
    endcase
  end

  // Interrupt saves carry no exception PC and are left out
  assign save_vld = save_cause_i && !save_irq_i && save_known;

  // Actual side records the first mepc the core wrote for each cause
  first_pc_bank u_actual (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .cap_i       (save_vld),
    .cap_cause_i (save_cause),
    .cap_pc_i    (mepc_n_i),
    .vld_o       (act_vld),
    .pc_o        (act_pc)
  );

  ////////////////////
  // Compare
  ////////////////////

  always_comb begin
    for (int i = 0; i < `TM_NUM_CAUSES; i++) begin
      mismatch[i] = exp_vld[i] && act_vld[i] && (exp_pc[i] != act_pc[i]);
    end
  end

  // Error bits stay set until reset
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_q | mismatch;
    end
  end

  assign mepc_err_o = err_q;

  // Any exception save must name one of the tracked synchronous causes
  a_save_code_known : assert property (@(posedge clk) disable iff (!rst_ni)
    (save_cause_i && !save_irq_i) |-> save_known);

endmodule

`default_nettype wire

// File: verilog/step_monitor.sv
// Single-step retirement check
`timescale 1ns/10ps
`default_nettype none

module step_monitor (
  input  logic clk,
  input  logic rst_ni,
  input  logic step_i,
  input  logic debug_mode_i,
  input  logic wb_valid_i,
  input  logic irq_ack_i,
  output logic step_err_o
);

  // An interrupt was taken while stepping and debug mode is still ahead
  logic irq_taken_q;
  // One instruction has already retired in the current step
  logic one_ret_q;
  logic step_retire;
  logic err_q;

  ////////////////////
  // Interrupt suspend
  ////////////////////

  // The handler's first instruction may retire as well, so the check pauses
  // until the core reaches debug mode
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      irq_taken_q <= 1'b0;
    end else if (irq_ack_i) begin
      irq_taken_q <= 1'b1;
    end else if (debug_mode_i) begin
      irq_taken_q <= 1'b0;
    end
  end

  ////////////////////
  // Retirement count
  ////////////////////

  // A retirement that counts against the one allowed per step
  assign step_retire = wb_valid_i && step_i && !debug_mode_i && !irq_taken_q;

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      one_ret_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      // Entering debug mode or leaving step mode starts a fresh step
      if (debug_mode_i || !step_i) begin
        one_ret_q <= 1'b0;
      end else if (step_retire) begin
        one_ret_q <= 1'b1;
      end
      // A second retirement in the same step is the violation
      if (step_retire && one_ret_q) begin
        err_q <= 1'b1;
      end
    end
  end

  assign step_err_o = err_q;

  // The core acknowledges an interrupt instead of retiring, never alongside
  a_no_irq_with_retire : assert property (@(posedge clk) disable iff (!rst_ni)
    (step_i && !debug_mode_i) |-> !(irq_ack_i && wb_valid_i));

endmodule

`default_nettype wire

// File: verilog/priv_monitor.sv
// Privilege level rules
`timescale 1ns/10ps
`default_nettype none
`include "trap_mon_macros.svh"

module priv_monitor import trap_mon_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  priv_lvl_e                     priv_lvl_i,
  input  priv_lvl_e                     priv_lvl_if_i,
  input  priv_lvl_e                     mstatus_mpp_i,
  input  logic                          mret_id_i,
  input  logic                          mret_ex_i,
  input  logic                          mret_wb_i,
  input  logic                          trap_set_i,
  input  logic                          mret_set_i,
  input  logic                          kill_if_i,
  input  logic                          debug_mode_i,
  output logic [`TM_NUM_PRIV_RULES-1:0] priv_err_o
);

  // Previous fetch level, for detecting a change
  priv_lvl_e                      priv_lvl_if_q;
  // Low in the first cycle after reset, where no previous level exists
  logic                           started_q;
  logic                           if_changed;
  logic                           mret_in_pipe;
  logic [`TM_NUM_PRIV_RULES-1:0]  viol;
  logic [`TM_NUM_PRIV_RULES-1:0]  err_q;

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_if_q <= PRIV_M;
      started_q     <= 1'b0;
    end else begin
      priv_lvl_if_q <= priv_lvl_if_i;
      started_q     <= 1'b1;
    end
  end

  assign if_changed   = started_q && (priv_lvl_if_i != priv_lvl_if_q);
  assign mret_in_pipe = mret_id_i || mret_ex_i || mret_wb_i;

  ////////////////////
  // Rules
  ////////////////////

  always_comb begin
    // MRET in ID switches the fetch level early, and the current level
    // follows only when it retires
    viol[RULE_CONSISTENT] = (priv_lvl_if_i != priv_lvl_i) && !mret_in_pipe;
    // Dropping to user mode is only done by an MRET with mpp set to U
    viol[RULE_TO_U] = if_changed && (priv_lvl_if_i == PRIV_U) &&
                      !(mret_id_i && (mstatus_mpp_i == PRIV_U));
    // Rising to machine mode needs a trap, or a fetch kill restoring M
    viol[RULE_TO_M] = if_changed && (priv_lvl_if_i == PRIV_M) &&
                      !(trap_set_i || kill_if_i);
    // Traps fetch in M, and an MRET jump fetches in the mpp level
    viol[RULE_TRAP_M] = (trap_set_i && !debug_mode_i && (priv_lvl_if_i != PRIV_M)) ||
                        (mret_set_i && (priv_lvl_if_i != mstatus_mpp_i));
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_q | viol;
    end
  end

  assign priv_err_o = err_q;

  // The controller sets the PC from one source at a time
  a_trap_mret_excl : assert property (@(posedge clk) disable iff (!rst_ni)
    !(trap_set_i && mret_set_i));

endmodule

`default_nettype wire

// File: verilog/core_trap_monitor.sv
// Core trap and privilege monitor
`timescale 1ns/10ps
`default_nettype none
`include "trap_mon_macros.svh"

module core_trap_monitor import trap_mon_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_ni,
  // Writeback stage
  input  logic                          wb_valid_i,
  input  logic [`TM_XLEN-1:0]           wb_pc_i,
  input  logic                          wb_bus_err_i,
  input  logic                          wb_illegal_i,
  input  logic                          wb_ebreak_i,
  input  logic                          wb_ecall_i,
  input  logic                          irq_ack_i,
  // CSR save of mcause and mepc
  input  logic                          save_cause_i,
  input  logic                          save_irq_i,
  input  exc_code_e                     save_code_i,
  input  logic [`TM_XLEN-1:0]           mepc_n_i,
  // Debug and stepping
  input  logic                          step_i,
  input  logic                          debug_mode_i,
  // Privilege
  input  priv_lvl_e                     priv_lvl_i,
  input  priv_lvl_e                     priv_lvl_if_i,
  input  priv_lvl_e                     mstatus_mpp_i,
  input  logic                          mret_id_i,
  input  logic                          mret_ex_i,
  input  logic                          mret_wb_i,
  input  logic                          trap_set_i,
  input  logic                          mret_set_i,
  input  logic                          kill_if_i,
  output logic [`TM_NUM_CAUSES-1:0]     mepc_err_o,
  output logic                          step_err_o,
  output logic [`TM_NUM_PRIV_RULES-1:0] priv_err_o
);

  mepc_monitor u_mepc (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .wb_pc_i      (wb_pc_i),
    .wb_bus_err_i (wb_bus_err_i),
    .wb_illegal_i (wb_illegal_i),
    .wb_ebreak_i  (wb_ebreak_i),
    .wb_ecall_i   (wb_ecall_i),
    .irq_ack_i    (irq_ack_i),
    .debug_mode_i (debug_mode_i),
    .priv_lvl_i   (priv_lvl_i),
    .save_cause_i (save_cause_i),
    .save_irq_i   (save_irq_i),
    .save_code_i  (save_code_i),
    .mepc_n_i     (mepc_n_i),
    .mepc_err_o   (mepc_err_o)
  );

  step_monitor u_step (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .step_i       (step_i),
    .debug_mode_i (debug_mode_i),
    .wb_valid_i   (wb_valid_i),
    .irq_ack_i    (irq_ack_i),
    .step_err_o   (step_err_o)
  );

  priv_monitor u_priv (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .priv_lvl_i    (priv_lvl_i),
    .priv_lvl_if_i (priv_lvl_if_i),
    .mstatus_mpp_i (mstatus_mpp_i),
    .mret_id_i     (mret_id_i),
    .mret_ex_i     (mret_ex_i),
    .mret_wb_i     (mret_wb_i),
    .trap_set_i    (trap_set_i),
    .mret_set_i    (mret_set_i),
    .kill_if_i     (kill_if_i),
    .debug_mode_i  (debug_mode_i),
    .priv_err_o    (priv_err_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_core_trap_monitor.sv
// Trap monitor testbench
`timescale 1ns/10ps
`default_nettype none
`include "trap_mon_macros.svh"

module tb_core_trap_monitor import trap_mon_pkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  // Rough cycle budget of each test section for the watchdog
  localparam int MEPC_CYCLES   = 26;
  localparam int STEP_CYCLES   = 22;
  localparam int PRIV_CYCLES   = 12;
  localparam int MARGIN_CYCLES = 50;

  logic                                clk;
  logic                                rst_ni;
  logic                                wb_valid;
  logic [`TM_XLEN-1:0]                 wb_pc;
  logic                                wb_bus_err;
  logic                                wb_illegal;
  logic                                wb_ebreak;
  logic                                wb_ecall;
  logic                                irq_ack;
  logic                                save_cause;
  logic                                save_irq;
  exc_code_e                           save_code;
  logic [`TM_XLEN-1:0]                 mepc_n;
  logic                                step;
  logic                                debug_mode;
  priv_lvl_e                           priv_lvl;
  priv_lvl_e                           priv_lvl_if;
  priv_lvl_e                           mstatus_mpp;
  logic                                mret_id;
  logic                                mret_ex;
  logic                                mret_wb;
  logic                                trap_set;
  logic                                mret_set;
  logic                                kill_if;
  logic [`TM_NUM_CAUSES-1:0]           mepc_err;
  logic                                step_err;
  logic [`TM_NUM_PRIV_RULES-1:0]       priv_err;

  int                                  errors;
  string                               test_name;
  logic [31:0]                         lfsr_state;

  core_trap_monitor u_dut (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid),
    .wb_pc_i       (wb_pc),
    .wb_bus_err_i  (wb_bus_err),
    .wb_illegal_i  (wb_illegal),
    .wb_ebreak_i   (wb_ebreak),
    .wb_ecall_i    (wb_ecall),
    .irq_ack_i     (irq_ack),
    .save_cause_i  (save_cause),
    .save_irq_i    (save_irq),
    .save_code_i   (save_code),
    .mepc_n_i      (mepc_n),
    .step_i        (step),
    .debug_mode_i  (debug_mode),
    .priv_lvl_i    (priv_lvl),
    .priv_lvl_if_i (priv_lvl_if),
    .mstatus_mpp_i (mstatus_mpp),
    .mret_id_i     (mret_id),
    .mret_ex_i     (mret_ex),
    .mret_wb_i     (mret_wb),
    .trap_set_i    (trap_set),
    .mret_set_i    (mret_set),
    .kill_if_i     (kill_if),
    .mepc_err_o    (mepc_err),
    .step_err_o    (step_err),
    .priv_err_o    (priv_err)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Fibonacci LFSR that takes one step per bit handed out
  function automatic logic [31:0] lfsr_word();
    logic [31:0] word;
    logic        fb;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      // Taps of x^32 + x^22 + x^2 + x + 1
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      word       = {word[30:0], fb};
    end
    return word;
  endfunction

  // Word aligned random PC
  function automatic logic [31:0] rand_pc();
    logic [31:0] word;
    word = lfsr_word();
    return {word[31:2], 2'b00};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    errors++;
    $display("[FAIL] %s (%s): expected %0h, actual %0h", test_name, what, exp_val, act_val);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  logic [`TM_NUM_CAUSES-1:0]     ref_exp_vld;
  logic [`TM_NUM_CAUSES-1:0]     ref_act_vld;
  logic [`TM_XLEN-1:0]           ref_exp_pc [`TM_NUM_CAUSES];
  logic [`TM_XLEN-1:0]           ref_act_pc [`TM_NUM_CAUSES];
  logic [`TM_NUM_CAUSES-1:0]     exp_mepc_err;
  logic                          ref_irq_pend;
  logic                          ref_retired;
  logic                          exp_step_err;
  priv_lvl_e                     ref_prev_if;
  logic                          ref_started;
  logic [`TM_NUM_PRIV_RULES-1:0] exp_priv_err;

  always @(posedge clk or negedge rst_ni) begin : ref_model
    logic       wb_hit;
    logic [2:0] wb_idx;
    logic       sv_hit;
    logic [2:0] sv_idx;
    logic       counts;
    logic       if_moved;
    if (!rst_ni) begin
      ref_exp_vld  <= '0;
      ref_act_vld  <= '0;
      exp_mepc_err <= '0;
      ref_irq_pend <= 1'b0;
      ref_retired  <= 1'b0;
      exp_step_err <= 1'b0;
      ref_prev_if  <= PRIV_M;
      ref_started  <= 1'b0;
      exp_priv_err <= '0;
    end else begin
      // Cause the writeback instruction should trap with, if any
      wb_hit = wb_valid && !irq_ack && !debug_mode;
      wb_idx = CAUSE_EBREAK;
      if (wb_bus_err) begin
        wb_idx = CAUSE_BUS_FAULT;
      end else if (wb_illegal) begin
        wb_idx = CAUSE_ILLEGAL;
      end else if (wb_ecall) begin
        wb_idx = (priv_lvl == PRIV_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
      end else if (!wb_ebreak) begin
        wb_hit = 1'b0;
      end
      // Cause named by the saved mcause code
      sv_hit = save_cause && !save_irq;
      sv_idx = CAUSE_BUS_FAULT;
      case (save_code)
        EXC_ILLEGAL:    sv_idx = CAUSE_ILLEGAL;
        EXC_BREAKPOINT: sv_idx = CAUSE_EBREAK;
        EXC_ECALL_U:    sv_idx = CAUSE_ECALL_U;
        EXC_ECALL_M:    sv_idx = CAUSE_ECALL_M;
        default:        sv_idx = CAUSE_BUS_FAULT;
      endcase
      // The flag follows the edge where both first values are known
      for (int i = 0; i < `TM_NUM_CAUSES; i++) begin
        if (ref_exp_vld[i] && ref_act_vld[i] && (ref_exp_pc[i] != ref_act_pc[i])) begin
          exp_mepc_err[i] <= 1'b1;
        end
      end
      if (wb_hit && !ref_exp_vld[wb_idx]) begin
        ref_exp_vld[wb_idx] <= 1'b1;
        ref_exp_pc[wb_idx]  <= wb_pc;
      end
      if (sv_hit && !ref_act_vld[sv_idx]) begin
        ref_act_vld[sv_idx] <= 1'b1;
        ref_act_pc[sv_idx]  <= mepc_n;
      end
      // At most one retirement per step unless an interrupt was taken
      counts = wb_valid && step && !debug_mode && !ref_irq_pend;
      if (counts && ref_retired) begin
        exp_step_err <= 1'b1;
      end
      ref_retired <= (debug_mode || !step) ? 1'b0 : (ref_retired || counts);
      if (irq_ack) begin
        ref_irq_pend <= 1'b1;
      end else if (debug_mode) begin
        ref_irq_pend <= 1'b0;
      end
      // Privilege rules
      if_moved = ref_started && (priv_lvl_if != ref_prev_if);
      if ((priv_lvl_if != priv_lvl) && !(mret_id || mret_ex || mret_wb)) begin
        exp_priv_err[RULE_CONSISTENT] <= 1'b1;
      end
      if (if_moved && (priv_lvl_if == PRIV_U) && !(mret_id && (mstatus_mpp == PRIV_U))) begin
        exp_priv_err[RULE_TO_U] <= 1'b1;
      end
      if (if_moved && (priv_lvl_if == PRIV_M) && !trap_set && !kill_if) begin
        exp_priv_err[RULE_TO_M] <= 1'b1;
      end
      if ((trap_set && !debug_mode && (priv_lvl_if != PRIV_M)) ||
          (mret_set && (priv_lvl_if != mstatus_mpp))) begin
        exp_priv_err[RULE_TRAP_M] <= 1'b1;
      end
      ref_prev_if <= priv_lvl_if;
      ref_started <= 1'b1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  a_mepc_match : assert property (@(posedge clk) disable iff (!rst_ni)
    mepc_err == exp_mepc_err)
    else report_mismatch("mepc_err", 32'($sampled(exp_mepc_err)), 32'($sampled(mepc_err)));

  a_step_match : assert property (@(posedge clk) disable iff (!rst_ni)
    step_err == exp_step_err)
    else report_mismatch("step_err", 32'($sampled(exp_step_err)), 32'($sampled(step_err)));

  a_priv_match : assert property (@(posedge clk) disable iff (!rst_ni)
    priv_err == exp_priv_err)
    else report_mismatch("priv_err", 32'($sampled(exp_priv_err)), 32'($sampled(priv_err)));

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic strobes_low();
    wb_valid   <= 1'b0;
    wb_bus_err <= 1'b0;
    wb_illegal <= 1'b0;
    wb_ebreak  <= 1'b0;
    wb_ecall   <= 1'b0;
    irq_ack    <= 1'b0;
    save_cause <= 1'b0;
    save_irq   <= 1'b0;
    trap_set   <= 1'b0;
    mret_set   <= 1'b0;
    kill_if    <= 1'b0;
    mret_id    <= 1'b0;
    mret_ex    <= 1'b0;
    mret_wb    <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      strobes_low();
    end
  endtask

  task automatic retire_instr(input logic [31:0] pc, input logic bus, input logic ill,
                              input logic ecall, input logic ebreak, input logic irq);
    @(posedge clk);
    strobes_low();
    wb_valid   <= 1'b1;
    wb_pc      <= pc;
    wb_bus_err <= bus;
    wb_illegal <= ill;
    wb_ecall   <= ecall;
    wb_ebreak  <= ebreak;
    irq_ack    <= irq;
  endtask

  // mcause and mepc write together with the jump to the handler in machine mode
  task automatic save_trap(input exc_code_e code, input logic [31:0] mepc, input logic irq);
    @(posedge clk);
    strobes_low();
    save_cause  <= 1'b1;
    save_irq    <= irq;
    save_code   <= code;
    mepc_n      <= mepc;
    trap_set    <= 1'b1;
    priv_lvl    <= PRIV_M;
    priv_lvl_if <= PRIV_M;
  endtask

  // MRET walks through ID, EX and WB and the current level follows at the end
  task automatic mret_to_user();
    @(posedge clk);
    strobes_low();
    mret_id     <= 1'b1;
    mret_set    <= 1'b1;
    mstatus_mpp <= PRIV_U;
    priv_lvl_if <= PRIV_U;
    @(posedge clk);
    strobes_low();
    mret_ex <= 1'b1;
    @(posedge clk);
    strobes_low();
    mret_wb <= 1'b1;
    @(posedge clk);
    strobes_low();
    priv_lvl <= PRIV_U;
  endtask

  task automatic set_priv(input priv_lvl_e cur, input priv_lvl_e fetch);
    @(posedge clk);
    strobes_low();
    priv_lvl    <= cur;
    priv_lvl_if <= fetch;
  endtask

  task automatic enter_debug();
    @(posedge clk);
    strobes_low();
    debug_mode <= 1'b1;
    @(posedge clk);
    strobes_low();
    debug_mode <= 1'b0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    logic [31:0] pc;
    errors      = 0;
    lfsr_state  = 32'h8e284430;
    test_name   = "reset";
    rst_ni      = 1'b0;
    wb_pc       = '0;
    save_code   = EXC_INSTR_BUS_FAULT;
    mepc_n      = '0;
    step        = 1'b0;
    debug_mode  = 1'b0;
    priv_lvl    = PRIV_M;
    priv_lvl_if = PRIV_M;
    mstatus_mpp = PRIV_M;
    strobes_low();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_ni <= 1'b1;
    idle(2);
    @(negedge clk);
    a_reset_clear : assert ((mepc_err == '0) && !step_err && (priv_err == '0))
      else report_mismatch("all flags", 32'h0, 32'({mepc_err, step_err, priv_err}));

    // An interrupt in writeback and an interrupt save capture nothing
    test_name = "mepc suppression";
    retire_instr(rand_pc(), 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    save_trap(EXC_ECALL_M, rand_pc(), 1'b1);
    // Bus fault outranks illegal
    test_name = "mepc priority";
    pc = rand_pc();
    retire_instr(pc, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    save_trap(EXC_INSTR_BUS_FAULT, pc, 1'b0);
    test_name = "mepc illegal";
    pc = rand_pc();
    retire_instr(pc, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    save_trap(EXC_ILLEGAL, pc, 1'b0);
    test_name = "mepc ebreak mismatch";
    pc = rand_pc();
    retire_instr(pc, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    save_trap(EXC_BREAKPOINT, pc + 32'd4, 1'b0);
    idle(2);
    test_name = "mepc ecall m";
    pc = rand_pc();
    retire_instr(pc, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    save_trap(EXC_ECALL_M, pc, 1'b0);
    // Drop to user mode legally, then trap back to machine mode
    test_name = "mepc ecall u";
    mret_to_user();
    pc = rand_pc();
    retire_instr(pc, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    save_trap(EXC_ECALL_U, pc, 1'b0);
    test_name = "mepc repeat";
    pc = rand_pc();
    retire_instr(pc, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    save_trap(EXC_INSTR_BUS_FAULT, pc ^ 32'h10, 1'b0);
    idle(2);

    test_name = "step legal";
    @(posedge clk);
    strobes_low();
    step <= 1'b1;
    retire_instr(rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(1);
    enter_debug();
    retire_instr(rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    enter_debug();
    // The handler may retire freely until debug mode is reached
    test_name = "step after irq";
    @(posedge clk);
    strobes_low();
    irq_ack <= 1'b1;
    repeat (3) retire_instr(rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    enter_debug();
    test_name = "step violation";
    repeat (2) retire_instr(rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    @(posedge clk);
    strobes_low();
    step <= 1'b0;

    test_name = "priv consistent";
    set_priv(PRIV_U, PRIV_M);
    set_priv(PRIV_M, PRIV_M);
    test_name = "priv to user";
    set_priv(PRIV_U, PRIV_U);
    test_name = "priv to machine";
    set_priv(PRIV_M, PRIV_M);
    // mpp is still U, so an MRET jump that fetches in M is wrong
    test_name = "priv mret target";
    @(posedge clk);
    strobes_low();
    mret_set <= 1'b1;
    idle(2);

    test_name = "final";
    @(negedge clk);
    // Only the ebreak entry saw a wrong mepc
    a_final_mepc : assert (mepc_err == 5'b00100)
      else report_mismatch("mepc_err", 32'h4, 32'(mepc_err));
    a_final_step : assert (step_err)
      else report_mismatch("step_err", 32'h1, 32'(step_err));
    a_final_priv : assert (priv_err == 4'hf)
      else report_mismatch("priv_err", 32'hf, 32'(priv_err));

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the cycle budget of all sections
  initial begin : watchdog
    #((RESET_CYCLES + MEPC_CYCLES + STEP_CYCLES + PRIV_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in its cycle budget");
    $display("Errors: %0d", errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/trap_mon_pkg.sv
verilog/exc_classifier.sv
verilog/first_pc_bank.sv
verilog/mepc_monitor.sv
verilog/step_monitor.sv
verilog/priv_monitor.sv
verilog/core_trap_monitor.sv
verif/tb_core_trap_monitor.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/10ps -f list.f \
  --top-module tb_core_trap_monitor || exit 1
sim_out="$(./obj_dir/Vtb_core_trap_monitor)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Result: PASSED" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
